//--- common/bfPkg.sv
package bfPkg;

	// ====================
	// widths and basic types
	// ====================

	// fixed at 64, the 6-bit mb/me fields only address this width
	localparam int dataWidth = 64;

	typedef logic [dataWidth-1:0] dataWord;
	typedef logic [2:0] regIdx;
	typedef logic [31:0] instrWord;

	// ====================
	// instruction layout
	// ====================

	// bit 24 is unused
	localparam int opHi = 31;
	localparam int opLo = 25;
	localparam int rbHi = 23;
	localparam int rbLo = 21;
	localparam int raHi = 20;
	localparam int raLo = 18;
	localparam int rdHi = 17;
	localparam int rdLo = 15;
	localparam int meHi = 14;
	localparam int meLo = 9;
	localparam int mbHi = 8;
	localparam int mbLo = 3;
	localparam int fnHi = 2;
	localparam int fnLo = 0;

	// mask rule
	//   mb <= me : mask covers bits mb..me
	//   mb >  me : mask wraps, bits mb..63 and bits 0..me
	//   field length minus one is (me - mb) mod 64

	// only the bitfield major opcode executes, anything else writes zero
	typedef enum logic [6:0] {
		opBitfield = 7'd3
	} bfOpcode;

	// func code 7 is undefined and also writes zero
	typedef enum logic [2:0] {
		fnIns  = 3'd0,
		fnSet  = 3'd1,
		fnClr  = 3'd2,
		fnChg  = 3'd3,
		fnExtu = 3'd4,
		fnExts = 3'd5,
		fnSext = 3'd6
	} bfFunc;

	// lane sequencing
	typedef enum logic [1:0] {
		stIdle = 2'd0,
		stReq  = 2'd1,
		stDone = 2'd2
	} laneState;

endpackage

//--- common/rfBusIf.sv
`timescale 1ns/1ps

// one requester's view of the register file port
interface rfBusIf import bfPkg::*; ();

	// handshake, req is a level, gnt is combinational
	logic req;
	logic gnt;

	// read addresses and combinational read data
	regIdx raAddr;
	regIdx rbAddr;
	dataWord aData;
	dataWord bData;

	// write, only valid in the grant cycle
	logic we;
	regIdx wAddr;
	dataWord wData;

	modport lane (
		output req, raAddr, rbAddr, we, wAddr, wData,
		input gnt, aData, bData
	);

	modport arb (
		input req, raAddr, rbAddr, we, wAddr, wData,
		output gnt, aData, bData
	);

	// memory side accepts whatever the arbiter forwards
	modport mem (
		input req, raAddr, rbAddr, we, wAddr, wData,
		output gnt, aData, bData
	);

endinterface

//--- hw/bitfieldUnit.sv
`timescale 1ns/1ps

module bitfieldUnit import bfPkg::*; (
	input instrWord instr,
	input dataWord a,
	input dataWord b,
	output dataWord result,
	output dataWord mask
);

	bfOpcode opcode;
	bfFunc func;
	logic [5:0] mb;
	logic [5:0] me;
	// field length minus one, wraps mod 64
	logic [5:0] ml;

	assign opcode = bfOpcode'(instr[opHi:opLo]);
	assign func = bfFunc'(instr[fnHi:fnLo]);
	assign mb = instr[mbHi:mbLo];
	assign me = instr[meHi:meLo];
	assign ml = me - mb;

	// ====================
	// mask generation
	// ====================

	// three-way xor covers both the plain and the wrapped case
	always_comb begin
		for (int n = 0; n < dataWidth; n++) begin
			mask[n] = (n >= int'(mb)) ^ (n <= int'(me)) ^ (me >= mb);
		end
	end

	// ====================
	// operations
	// ====================

	always_comb begin
		dataWord shifted;
		dataWord masked;
		dataWord extracted;

		shifted = a << mb;
		masked = a & mask;
		extracted = masked >> mb;
		result = '0;

		if (opcode == opBitfield) begin
			case (func)
				// shifted a into the field, b elsewhere
				fnIns: result = (shifted & mask) | (b & ~mask);
				fnSet: result = a | mask;
				fnClr: result = a & ~mask;
				fnChg: result = a ^ mask;
				fnExtu: result = extracted;
				fnExts: begin
					// top bit of the field copied upward
					for (int n = 0; n < dataWidth; n++) begin
						result[n] = (n > int'(ml)) ? extracted[ml] : extracted[n];
					end
				end
				fnSext: begin
					// bit mb of a replaces every masked bit
					for (int n = 0; n < dataWidth; n++) begin
						result[n] = mask[n] ? a[mb] : a[n];
					end
				end
				default: result = '0;
			endcase
		end
	end

endmodule

//--- hw/bitfieldLane.sv
`timescale 1ns/1ps

module bitfieldLane import bfPkg::*; (
	input logic clk,
	input logic arstN,
	input logic cmd,
	input instrWord instr,
	output logic busy,
	output logic done,
	rfBusIf.lane bus
);

	laneState state;
	// latched command, payload only
	instrWord instrQ;
	dataWord result;

	// ====================
	// sequencing
	// ====================

	// idle -> req on a strobe, req -> done on grant, done lasts one cycle
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= stIdle;
		end else begin
			case (state)
				stIdle: begin
					if (cmd) begin
						state <= stReq;
					end
				end
				stReq: begin
					if (bus.gnt) begin
						state <= stDone;
					end
				end
				default: state <= stIdle;
			endcase
		end
	end

	// strobes while busy are dropped
	always_ff @(posedge clk) begin
		if (state == stIdle && cmd) begin
			instrQ <= instr;
		end
	end

	assign busy = (state != stIdle);
	assign done = (state == stDone);

	// ====================
	// register file access
	// ====================

	assign bus.req = (state == stReq);
	assign bus.raAddr = instrQ[raHi:raLo];
	assign bus.rbAddr = instrQ[rbHi:rbLo];
	assign bus.wAddr = instrQ[rdHi:rdLo];

	// read data arrives combinationally in the grant cycle
	bitfieldUnit unit0 (
		.instr (instrQ),
		.a     (bus.aData),
		.b     (bus.bData),
		.result(result),
		.mask  ()
	);

	// write lands on the edge closing the grant cycle
	assign bus.we = bus.req & bus.gnt;
	assign bus.wData = result;

endmodule

//--- hw/rfArbiter.sv
`timescale 1ns/1ps

module rfArbiter (
	input logic clk,
	input logic arstN,
	rfBusIf.arb lane0,
	rfBusIf.arb lane1,
	rfBusIf.lane mem
);

	// set means lane 1 wins the next tie
	logic favour1;
	logic pick0;
	logic pick1;

	// ====================
	// round robin pick
	// ====================

	assign pick0 = lane0.req & (~lane1.req | ~favour1);
	assign pick1 = lane1.req & (~lane0.req | favour1);

	// memory side accepts any forwarded request
	assign lane0.gnt = pick0 & mem.gnt;
	assign lane1.gnt = pick1 & mem.gnt;

	// pointer moves away from whoever was just served
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			favour1 <= 1'b0;
		end else if (lane0.gnt) begin
			favour1 <= 1'b1;
		end else if (lane1.gnt) begin
			favour1 <= 1'b0;
		end
	end

	// ====================
	// steering
	// ====================

	assign mem.req = lane0.req | lane1.req;
	assign mem.raAddr = pick1 ? lane1.raAddr : lane0.raAddr;
	assign mem.rbAddr = pick1 ? lane1.rbAddr : lane0.rbAddr;
	assign mem.we = pick1 ? lane1.we : lane0.we;
	assign mem.wAddr = pick1 ? lane1.wAddr : lane0.wAddr;
	assign mem.wData = pick1 ? lane1.wData : lane0.wData;

	// only the granted lane looks at the read data
	assign lane0.aData = mem.aData;
	assign lane0.bData = mem.bData;
	assign lane1.aData = mem.aData;
	assign lane1.bData = mem.bData;

endmodule

//--- hw/regFile.sv
`timescale 1ns/1ps

module regFile import bfPkg::*; (
	input logic clk,
	input logic arstN,
	rfBusIf.mem bus,
	input logic hostWe,
	input regIdx hostAddr,
	input dataWord hostData,
	input regIdx peekAddr,
	output dataWord peekData
);

	dataWord regs [8];

	// single port, always ready
	assign bus.gnt = bus.req;

	// combinational reads
	assign bus.aData = regs[bus.raAddr];
	assign bus.bData = regs[bus.rbAddr];
	assign peekData = regs[peekAddr];

	// host write checked first so it wins a same-address clash
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= '0;
			end
		end else begin
			for (int i = 0; i < 8; i++) begin
				if (hostWe && hostAddr == regIdx'(i)) begin
					regs[i] <= hostData;
				end else if (bus.we && bus.wAddr == regIdx'(i)) begin
					regs[i] <= bus.wData;
				end
			end
		end
	end

endmodule

//--- hw/bitfieldEngine.sv
`timescale 1ns/1ps

module bitfieldEngine import bfPkg::*; (
	input logic clk,
	input logic arstN,
	// lane 0 command
	input logic cmd0,
	input instrWord instr0,
	output logic busy0,
	output logic done0,
	// lane 1 command
	input logic cmd1,
	input instrWord instr1,
	output logic busy1,
	output logic done1,
	// host access, bypasses the arbiter
	input logic hostWe,
	input regIdx hostAddr,
	input dataWord hostData,
	input regIdx peekAddr,
	output dataWord peekData
);

	// ====================
	// buses
	// ====================

	rfBusIf bus0 ();
	rfBusIf bus1 ();
	rfBusIf memBus ();

	// ====================
	// lanes
	// ====================

	bitfieldLane lane0 (
		.clk  (clk),
		.arstN(arstN),
		.cmd  (cmd0),
		.instr(instr0),
		.busy (busy0),
		.done (done0),
		.bus  (bus0.lane)
	);

	bitfieldLane lane1 (
		.clk  (clk),
		.arstN(arstN),
		.cmd  (cmd1),
		.instr(instr1),
		.busy (busy1),
		.done (done1),
		.bus  (bus1.lane)
	);

	// ====================
	// shared port
	// ====================

	rfArbiter arb0 (
		.clk  (clk),
		.arstN(arstN),
		.lane0(bus0.arb),
		.lane1(bus1.arb),
		.mem  (memBus.lane)
	);

	regFile rf0 (
		.clk     (clk),
		.arstN   (arstN),
		.bus     (memBus.mem),
		.hostWe  (hostWe),
		.hostAddr(hostAddr),
		.hostData(hostData),
		.peekAddr(peekAddr),
		.peekData(peekData)
	);

endmodule

//--- tb/bitfieldEngine_props.sv
`timescale 1ns/1ps

module bitfieldEngine_props import bfPkg::*; (
	input logic clk,
	input logic arstN,
	input logic gnt0,
	input logic gnt1,
	input laneState st0,
	input laneState st1,
	input logic done0,
	input logic done1
);

	// ====================
	// arbitration
	// ====================

	// at most one lane owns the port
	grantOneHot: assert property (@(posedge clk) disable iff (!arstN) !(gnt0 && gnt1))
		else $error("both lanes granted in one cycle");

	// a lane that loses a tie is served in the next cycle
	serve0: assert property (@(posedge clk) disable iff (!arstN)
		(st0 == stReq && !gnt0) |=> gnt0)
		else $error("lane 0 waited more than two cycles for a grant");
	serve1: assert property (@(posedge clk) disable iff (!arstN)
		(st1 == stReq && !gnt1) |=> gnt1)
		else $error("lane 1 waited more than two cycles for a grant");

	// ====================
	// completion
	// ====================

	donePulse0: assert property (@(posedge clk) disable iff (!arstN) done0 |=> !done0)
		else $error("done0 high for more than one cycle");
	donePulse1: assert property (@(posedge clk) disable iff (!arstN) done1 |=> !done1)
		else $error("done1 high for more than one cycle");

endmodule

bind bitfieldEngine bitfieldEngine_props props0 (
	.clk  (clk),
	.arstN(arstN),
	.gnt0 (bus0.gnt),
	.gnt1 (bus1.gnt),
	.st0  (lane0.state),
	.st1  (lane1.state),
	.done0(done0),
	.done1(done1)
);

//--- tb/tb_bitfieldEngine.sv
`timescale 1ns/1ps

module tb_bitfieldEngine import bfPkg::*; ();

	// command counts per test group, used to size the watchdog
	localparam int cmdCount = 21 + 8 + 12 + 1 + 2 + 2;
	localparam int watchdogCycles = cmdCount * 10 + 400;

	logic clk;
	logic arstN;
	logic cmd0;
	logic cmd1;
	instrWord instr0;
	instrWord instr1;
	logic busy0;
	logic busy1;
	logic done0;
	logic done1;
	logic hostWe;
	regIdx hostAddr;
	dataWord hostData;
	regIdx peekAddr;
	dataWord peekData;

	// reference copy of the register file
	dataWord model [8];
	integer seed = 14510;
	int wordErrs = 0;
	int flagErrs = 0;
	int otherErrs = 0;

	bitfieldEngine dut0 (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ====================
	// reference model
	// ====================

	function automatic dataWord refOp(instrWord ins, dataWord a, dataWord b);
		logic [5:0] mb;
		logic [5:0] me;
		logic [5:0] ml;
		dataWord m;
		dataWord v;
		dataWord fill;
		mb = ins[mbHi:mbLo];
		me = ins[meHi:meLo];
		ml = me - mb;
		// plain field when mb <= me, otherwise it wraps past bit 63
		for (int n = 0; n < dataWidth; n++) begin
			if (mb <= me) begin
				m[n] = (n >= int'(mb)) && (n <= int'(me));
			end else begin
				m[n] = (n >= int'(mb)) || (n <= int'(me));
			end
		end
		v = (a & m) >> mb;
		// every bit above the top of the field, empty for a full field
		fill = ~((dataWord'(2) << ml) - 64'd1);
		if (ins[opHi:opLo] != opBitfield) begin
			return '0;
		end
		case (ins[fnHi:fnLo])
			fnIns: return ((a << mb) & m) | (b & ~m);
			fnSet: return a | m;
			fnClr: return a & ~m;
			fnChg: return a ^ m;
			fnExtu: return v;
			fnExts: return v[ml] ? (v | fill) : v;
			fnSext: return a[mb] ? (a | m) : (a & ~m);
			default: return '0;
		endcase
	endfunction

	task automatic applyModel(instrWord ins);
		model[ins[rdHi:rdLo]] = refOp(ins, model[ins[raHi:raLo]], model[ins[rbHi:rbLo]]);
	endtask

	// ====================
	// stimulus helpers
	// ====================

	function automatic logic [31:0] nextRand();
		return $random(seed);
	endfunction

	function automatic instrWord makeInstr(logic [6:0] op, regIdx rb, regIdx ra, regIdx rd,
			logic [5:0] me, logic [5:0] mb, logic [2:0] fn);
		instrWord w;
		w = '0;
		w[opHi:opLo] = op;
		w[rbHi:rbLo] = rb;
		w[raHi:raLo] = ra;
		w[rdHi:rdLo] = rd;
		w[meHi:meLo] = me;
		w[mbHi:mbLo] = mb;
		w[fnHi:fnLo] = fn;
		return w;
	endfunction

	// wrap set picks mb > me, clear picks mb <= me
	function automatic instrWord randInstr(logic [2:0] fn, logic wrap, regIdx rd);
		logic [5:0] mb;
		logic [5:0] me;
		logic [5:0] t;
		mb = 6'(nextRand());
		me = 6'(nextRand());
		if ((wrap && mb < me) || (!wrap && mb > me)) begin
			t = mb;
			mb = me;
			me = t;
		end
		if (wrap && mb == me) begin
			if (me == 6'd0) mb = 6'd1;
			else me = me - 6'd1;
		end
		return makeInstr(opBitfield, regIdx'(nextRand()), regIdx'(nextRand()), rd, me, mb, fn);
	endfunction

	task automatic hostWrite(regIdx idx, dataWord data);
		@(posedge clk);
		hostWe <= 1'b1;
		hostAddr <= idx;
		hostData <= data;
		@(posedge clk);
		hostWe <= 1'b0;
		model[idx] = data;
	endtask

	// returns right after the capture edge
	task automatic startLanes(logic use0, logic use1, instrWord i0, instrWord i1);
		@(posedge clk);
		cmd0 <= use0;
		cmd1 <= use1;
		instr0 <= i0;
		instr1 <= i1;
		@(posedge clk);
		cmd0 <= 1'b0;
		cmd1 <= 1'b0;
	endtask

	// model follows the order in which done shows up, which is the write order
	task automatic waitLanes(logic want0, logic want1, instrWord i0, instrWord i1);
		int cycles;
		logic pend0;
		logic pend1;
		cycles = 0;
		pend0 = want0;
		pend1 = want1;
		while ((pend0 || pend1) && cycles < 3) begin
			@(negedge clk);
			cycles++;
			if (cycles == 1 && want0) checkFlag("busy0", busy0, 1'b1);
			if (cycles == 1 && want1) checkFlag("busy1", busy1, 1'b1);
			if (pend0 && done0) begin
				applyModel(i0);
				pend0 = 1'b0;
			end
			if (pend1 && done1) begin
				applyModel(i1);
				pend1 = 1'b0;
			end
		end
		if (pend0 || pend1) begin
			otherErrs++;
			$display("lane done missing three cycles after the command at %0t", $time);
		end
	endtask

	// ====================
	// checks
	// ====================

	task automatic checkWord(string name, dataWord got, dataWord exp);
		if (got !== exp) begin
			wordErrs++;
			$display("Fail %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic checkFlag(string name, logic got, logic exp);
		if (got !== exp) begin
			flagErrs++;
			$display("Fail %0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic peekCheck(regIdx idx);
		@(posedge clk);
		peekAddr <= idx;
		@(negedge clk);
		checkWord($sformatf("peekData[%0d]", idx), peekData, model[idx]);
	endtask

	task automatic peekAll();
		for (int i = 0; i < 8; i++) peekCheck(regIdx'(i));
	endtask

	// ====================
	// test sequence
	// ====================

	initial begin
		instrWord w0;
		instrWord w1;
		regIdx rd0;
		regIdx rd1;
		cmd0 = 1'b0;
		cmd1 = 1'b0;
		instr0 = '0;
		instr1 = '0;
		hostWe = 1'b0;
		hostAddr = '0;
		hostData = '0;
		peekAddr = '0;
		for (int i = 0; i < 8; i++) model[i] = '0;
		arstN = 1'b0;
		repeat (2) @(posedge clk);
		arstN <= 1'b1;

		// reset state
		@(negedge clk);
		checkFlag("busy0", busy0, 1'b0);
		checkFlag("busy1", busy1, 1'b0);
		checkFlag("done0", done0, 1'b0);
		checkFlag("done1", done1, 1'b0);
		peekAll();

		// lane 0 alone, every func, plain masks
		for (int i = 0; i < 8; i++) hostWrite(regIdx'(i), {nextRand(), nextRand()});
		for (int f = 0; f < 7; f++) begin
			for (int r = 0; r < 3; r++) begin
				w0 = randInstr(3'(f), 1'b0, regIdx'(nextRand()));
				startLanes(1'b1, 1'b0, w0, '0);
				waitLanes(1'b1, 1'b0, w0, '0);
				peekCheck(w0[rdHi:rdLo]);
			end
		end

		// wrapped masks on insert, set, clear, change
		for (int k = 0; k < 8; k++) begin
			w0 = randInstr(3'(k % 4), 1'b1, regIdx'(nextRand()));
			startLanes(1'b1, 1'b0, w0, '0);
			waitLanes(1'b1, 1'b0, w0, '0);
			peekCheck(w0[rdHi:rdLo]);
		end

		// both lanes in the same cycle, distinct destinations
		for (int k = 0; k < 6; k++) begin
			rd0 = regIdx'(nextRand());
			rd1 = rd0 + regIdx'(1 + nextRand() % 7);
			w0 = randInstr(3'(nextRand() % 7), 1'b0, rd0);
			w1 = randInstr(3'(nextRand() % 7), 1'b1, rd1);
			// a lone lane 1 command hands the following ties to lane 0
			if (k == 3) begin
				startLanes(1'b0, 1'b1, '0, w1);
				waitLanes(1'b0, 1'b1, '0, w1);
				peekCheck(rd1);
			end
			startLanes(1'b1, 1'b1, w0, w1);
			waitLanes(1'b1, 1'b1, w0, w1);
			peekCheck(rd0);
			peekCheck(rd1);
		end

		// second strobe stays up through the whole busy window and must be dropped
		w0 = makeInstr(opBitfield, 3'd2, 3'd1, 3'd5, 6'd20, 6'd4, fnSet);
		w1 = makeInstr(opBitfield, 3'd2, 3'd1, 3'd5, 6'd20, 6'd4, fnClr);
		@(posedge clk);
		cmd0 <= 1'b1;
		instr0 <= w0;
		@(posedge clk);
		instr0 <= w1;
		waitLanes(1'b1, 1'b0, w0, '0);
		@(posedge clk);
		cmd0 <= 1'b0;
		peekCheck(3'd5);
		checkFlag("busy0", busy0, 1'b0);

		// foreign opcode and undefined func both clear rd
		hostWrite(3'd6, 64'hdead_beef_0bad_f00d);
		w0 = makeInstr(7'h10, 3'd1, 3'd2, 3'd6, 6'd40, 6'd8, fnSet);
		startLanes(1'b1, 1'b0, w0, '0);
		waitLanes(1'b1, 1'b0, w0, '0);
		peekCheck(3'd6);
		hostWrite(3'd6, 64'h0123_4567_89ab_cdef);
		w0 = makeInstr(opBitfield, 3'd1, 3'd2, 3'd6, 6'd40, 6'd8, 3'd7);
		startLanes(1'b1, 1'b0, w0, '0);
		waitLanes(1'b1, 1'b0, w0, '0);
		peekCheck(3'd6);
		peekAll();

		$display("errors: word %0d flag %0d other %0d", wordErrs, flagErrs, otherErrs);
		if (wordErrs + flagErrs + otherErrs == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	// watchdog
	initial begin
		repeat (watchdogCycles) @(posedge clk);
		$display("timeout, the test sequence did not finish in %0d cycles", watchdogCycles);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

//--- tb.f
common/bfPkg.sv
common/rfBusIf.sv
hw/bitfieldUnit.sv
hw/bitfieldLane.sv
hw/rfArbiter.sv
hw/regFile.sv
hw/bitfieldEngine.sv
tb/bitfieldEngine_props.sv
tb/tb_bitfieldEngine.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_bitfieldEngine
FILELIST ?= tb.f
BUILD ?= obj_dir
LOG ?= sim.log
PASS ?= ALL CHECKS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD) -o $(TOP)
	./$(BUILD)/$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "$(PASS)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
